// ==== tests/id_stage_input.txt ====
# name fv pc inst | es_allowin es_ctl addr value | ms_ctl addr value | ws_ctl addr value | rf_we addr data
# | mask valid allowin alu flags dest rs rt br_taken br_target   (ctl bit0 valid bit1 we bit2 load)
reset_idle 0 0 00000000 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 083 0 1 0 00 00 00000000 00000000 0 00000000
rf_wr1 0 0 00000000 1 0 00 00000000 0 00 00000000 0 00 00000000 1 01 11111111 083 0 1 0 00 00 00000000 00000000 0 00000000
rf_wr2 0 0 00000000 1 0 00 00000000 0 00 00000000 0 00 00000000 1 02 22222222 083 0 1 0 00 00 00000000 00000000 0 00000000
rf_wr0 1 0 00221821 1 0 00 00000000 0 00 00000000 0 00 00000000 1 00 deadbeef 083 0 1 0 00 00 00000000 00000000 0 00000000
addu 1 0 00022025 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 0ff 1 1 0 04 03 11111111 22222222 0 00000000
or_r0 1 0 00412823 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 0ff 1 1 6 04 04 00000000 22222222 0 00000000
subu 1 0 0022302a 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 0ff 1 1 1 04 05 22222222 11111111 0 00000000
slt 1 0 0022382b 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 2 04 06 00000000 00000000 0 00000000
sltu 1 0 00224024 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 3 04 07 00000000 00000000 0 00000000
and 1 0 00224826 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 4 04 08 00000000 00000000 0 00000000
xor 1 0 00225027 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 7 04 09 00000000 00000000 0 00000000
nor 1 0 00025900 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 5 04 0a 00000000 00000000 0 00000000
sll 1 0 00026102 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 8 84 0b 00000000 00000000 0 00000000
srl 1 0 00026903 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 9 84 0c 00000000 00000000 0 00000000
sra 1 0 242e0010 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 a 84 0d 00000000 00000000 0 00000000
addiu 1 0 302f00ff 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 0 24 0e 00000000 00000000 0 00000000
andi 1 0 343000ff 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 4 2c 0f 00000000 00000000 0 00000000
ori 1 0 383100ff 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 6 2c 10 00000000 00000000 0 00000000
xori 1 0 3c121234 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 7 2c 11 00000000 00000000 0 00000000
lui 1 0 8c330004 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 b 24 12 00000000 00000000 0 00000000
lw 1 0 ac220008 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 09f 1 1 0 25 13 00000000 00000000 0 00000000
sw_fwd 1 0 00221821 1 3 01 aaaaaaaa 3 01 bbbbbbbb 3 02 cccccccc 0 00 00000000 0ff 1 1 0 22 00 aaaaaaaa cccccccc 0 00000000
load_use 1 1000 10210010 1 7 01 aaaaaaaa 3 01 bbbbbbbb 0 00 00000000 0 00 00000000 0f3 0 0 0 00 03 bbbbbbbb 22222222 0 00000000
load_hold 1 1000 10210010 1 7 01 aaaaaaaa 3 01 bbbbbbbb 0 00 00000000 0 00 00000000 0f3 0 0 0 00 03 bbbbbbbb 22222222 0 00000000
load_done 1 1000 10210010 1 3 01 aaaaaaaa 3 01 bbbbbbbb 0 00 00000000 0 00 00000000 0f3 1 1 0 00 03 aaaaaaaa 22222222 0 00000000
beq_backp 1 2000 1422fffc 0 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 183 1 0 0 00 00 00000000 00000000 1 00001044
beq_taken 1 2000 1422fffc 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 183 1 1 0 00 00 00000000 00000000 1 00001044
bne_taken 1 2000 1421fffc 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 181 1 1 0 00 00 00000000 00000000 1 00001ff4
bne_not 1 0 10220010 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 081 1 1 0 00 00 00000000 00000000 0 00000000
beq_not 1 30000000 08000100 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 081 1 1 0 00 00 00000000 00000000 0 00000000
j 1 40000000 0c000200 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 181 1 1 0 00 00 00000000 00000000 1 30000400
jal 1 0 00400008 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 19d 1 1 0 54 1f 00000000 00000000 1 40000800
jr 0 0 00000000 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 181 1 1 0 00 00 00000000 00000000 1 22222222
drain 0 0 00000000 1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 083 0 1 0 00 00 00000000 00000000 0 00000000

// ==== tb.f ====
verilog/id_pkg.sv
verilog/id_latch.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/operand_bypass.sv
verilog/branch_resolve.sv
verilog/id_stage.sv
tests/id_stage_chk.sv
tests/id_stage_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = id_stage_tb
FILELIST  = tb.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tests/id_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage_tb import id_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        fs_to_ds_valid;
    logic [31:0] fs_pc;
    logic [31:0] fs_inst;
    logic        ds_allowin;
    logic        es_allowin;
    logic        ds_to_es_valid;
    alu_op_t     es_alu_op;
    logic        es_src1_is_sa;
    logic        es_src1_is_pc;
    logic        es_src2_is_imm;
    logic        es_src2_is_8;
    logic        es_zero_extend_imm;
    logic        es_gr_we;
    logic        es_mem_we;
    logic        es_load_op;
    logic [4:0]  es_dest;
    logic [15:0] es_imm;
    logic [31:0] es_rs_value;
    logic [31:0] es_rt_value;
    logic [31:0] es_pc;
    logic        es_fw_valid;
    logic        es_fw_we;
    logic        es_is_load;
    logic [4:0]  es_fw_addr;
    logic [31:0] es_fw_value;
    logic        ms_fw_valid;
    logic        ms_fw_we;
    logic [4:0]  ms_fw_addr;
    logic [31:0] ms_fw_value;
    logic        ws_fw_valid;
    logic        ws_fw_we;
    logic [4:0]  ws_fw_addr;
    logic [31:0] ws_fw_value;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic        br_taken;
    logic [31:0] br_target;

    string       lines[$];
    string       test_name;
    logic [31:0] f [0:25];   // numeric columns of the current line
    int          cycles = 0;
    int          limit = 1000;
    logic        held = 1'b0;   // latch has taken an instruction
    logic [31:0] held_pc;
    logic [31:0] held_inst;

    id_stage uut (.*);

    bind id_stage id_stage_chk chk (
        .clk(clk), .reset(reset), .ds_to_es_valid(ds_to_es_valid),
        .es_allowin(es_allowin), .ready_go(ready_go), .es_fw_valid(es_fw_valid),
        .es_is_load(es_is_load), .es_fw_addr(es_fw_addr), .es_dest(es_dest),
        .es_pc(es_pc), .ds_inst(ds_inst)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %0s %0s: expected %h actual %h",
                     test_name, what, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic apply_line(input string text);
        int n;
        n = $sscanf(text,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    test_name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                    f[18], f[19], f[20], f[21], f[22], f[23], f[24], f[25]);
        if (n != 27) begin
            $display("malformed stimulus line: %0s", text);
            $display("Result: FAILED");
            $fatal(1, "bad data file");
        end
        fs_to_ds_valid = f[0][0];
        fs_pc          = (f[1] != 32'd0) ? f[1] : ($urandom() & 32'hffff_fffc);
        fs_inst        = f[2];
        es_allowin     = f[3][0];
        es_fw_valid    = f[4][0];   // ctl bits are valid, we, load
        es_fw_we       = f[4][1];
        es_is_load     = f[4][2];
        es_fw_addr     = f[5][4:0];
        es_fw_value    = f[6];
        ms_fw_valid    = f[7][0];
        ms_fw_we       = f[7][1];
        ms_fw_addr     = f[8][4:0];
        ms_fw_value    = f[9];
        ws_fw_valid    = f[10][0];
        ws_fw_we       = f[10][1];
        ws_fw_addr     = f[11][4:0];
        ws_fw_value    = f[12];
        rf_we          = f[13][0];
        rf_waddr       = f[14][4:0];
        rf_wdata       = f[15];
    endtask

    task automatic check_outputs();
        logic [31:0] mask;
        mask = f[16];
        if (mask[0]) check("ds_to_es_valid", f[17], 32'(ds_to_es_valid));
        if (mask[1]) check("ds_allowin", f[18], 32'(ds_allowin));
        if (mask[2]) check("es_alu_op", f[19], 32'(es_alu_op));
        if (mask[3]) check("flags", f[20], 32'({es_src1_is_sa, es_src1_is_pc,
            es_src2_is_imm, es_src2_is_8, es_zero_extend_imm, es_gr_we,
            es_mem_we, es_load_op}));
        if (mask[4]) check("es_dest", f[21], 32'(es_dest));
        if (mask[5]) check("es_rs_value", f[22], es_rs_value);
        if (mask[6]) check("es_rt_value", f[23], es_rt_value);
        if (mask[7]) check("br_taken", f[24], 32'(br_taken));
        if (mask[8]) check("br_target", f[25], br_target);
        // pc and immediate follow the last word taken from fetch
        if (held) begin
            check("es_pc", held_pc, es_pc);
            check("es_imm", 32'(held_inst[15:0]), 32'(es_imm));
        end
    endtask

    initial begin
        string line;
        int    fd;
        void'($urandom(32'ha9768e8a));
        clk = 1'b0;
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_pc = 32'd0;
        fs_inst = 32'd0;
        es_allowin = 1'b1;
        {es_fw_valid, es_fw_we, es_is_load, es_fw_addr, es_fw_value} = '0;
        {ms_fw_valid, ms_fw_we, ms_fw_addr, ms_fw_value} = '0;
        {ws_fw_valid, ws_fw_we, ws_fw_addr, ws_fw_value} = '0;
        {rf_we, rf_waddr, rf_wdata} = '0;
        fd = $fopen("tests/id_stage_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/id_stage_input.txt");
            $display("Result: FAILED");
            $fatal(1, "missing data file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != 8'h23) lines.push_back(line);  // skip # lines
        end
        $fclose(fd);
        limit = lines.size() + 20;   // one cycle per data line plus slack
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        foreach (lines[i]) begin
            apply_line(lines[i]);
            @(negedge clk);
            check_outputs();
            if (fs_to_ds_valid && ds_allowin) begin   // transfer on the coming edge
                held      = 1'b1;
                held_pc   = fs_pc;
                held_inst = fs_inst;
            end
            @(posedge clk);
            #1;
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/id_stage_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage_chk (
    input logic        clk,
    input logic        reset,
    input logic        ds_to_es_valid,
    input logic        es_allowin,
    input logic        ready_go,
    input logic        es_fw_valid,
    input logic        es_is_load,
    input logic [4:0]  es_fw_addr,
    input logic [4:0]  es_dest,
    input logic [31:0] es_pc,
    input logic [31:0] ds_inst
);

    logic load_use;

    assign load_use = es_fw_valid && es_is_load && (es_fw_addr != 5'd0)
                      && (es_fw_addr == ds_inst[25:21] || es_fw_addr == ds_inst[20:16]);

    a_reset_quiet: assert property (@(posedge clk) reset |=> !ds_to_es_valid)
        else $error("ds_to_es_valid high after a reset cycle");

    // back-pressure freezes the outgoing instruction
    a_hold: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> $stable(es_pc) && $stable(es_dest))
        else $error("outputs moved while execute refused them");

    a_stall: assert property (@(posedge clk) disable iff (reset) load_use |-> !ready_go)
        else $error("load-use hazard did not stall decode");

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // fetch side
    input  logic        fs_to_ds_valid,
    input  logic [31:0] fs_pc,
    input  logic [31:0] fs_inst,
    output logic        ds_allowin,
    // execute side
    input  logic        es_allowin,
    output logic        ds_to_es_valid,
    output alu_op_t     es_alu_op,
    output logic        es_src1_is_sa,
    output logic        es_src1_is_pc,
    output logic        es_src2_is_imm,
    output logic        es_src2_is_8,
    output logic        es_zero_extend_imm,
    output logic        es_gr_we,
    output logic        es_mem_we,
    output logic        es_load_op,
    output logic [4:0]  es_dest,
    output logic [15:0] es_imm,
    output logic [31:0] es_rs_value,
    output logic [31:0] es_rt_value,
    output logic [31:0] es_pc,
    // forwarding from later stages
    input  logic        es_fw_valid,
    input  logic        es_fw_we,
    input  logic        es_is_load,
    input  logic [4:0]  es_fw_addr,
    input  logic [31:0] es_fw_value,
    input  logic        ms_fw_valid,
    input  logic        ms_fw_we,
    input  logic [4:0]  ms_fw_addr,
    input  logic [31:0] ms_fw_value,
    input  logic        ws_fw_valid,
    input  logic        ws_fw_we,
    input  logic [4:0]  ws_fw_addr,
    input  logic [31:0] ws_fw_value,
    // write-back port
    input  logic        rf_we,
    input  logic [4:0]  rf_waddr,
    input  logic [31:0] rf_wdata,
    // redirect to fetch
    output logic        br_taken,
    output logic [31:0] br_target
);

    logic        ds_valid;
    logic        ready_go;
    logic [31:0] ds_inst;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    br_kind_t    br_kind;

    assign ds_to_es_valid = ds_valid && ready_go;

    id_latch u_latch (
        .clk(clk), .reset(reset),
        .fs_to_ds_valid(fs_to_ds_valid), .fs_pc(fs_pc), .fs_inst(fs_inst),
        .es_allowin(es_allowin), .ready_go(ready_go), .ds_allowin(ds_allowin),
        .ds_valid(ds_valid), .ds_pc(es_pc), .ds_inst(ds_inst)
    );

    inst_decoder u_dec (
        .inst(ds_inst), .alu_op(es_alu_op),
        .src1_is_sa(es_src1_is_sa), .src1_is_pc(es_src1_is_pc),
        .src2_is_imm(es_src2_is_imm), .src2_is_8(es_src2_is_8),
        .zero_extend_imm(es_zero_extend_imm), .gr_we(es_gr_we),
        .mem_we(es_mem_we), .load_op(es_load_op),
        .dest(es_dest), .imm(es_imm), .br_kind(br_kind)
    );

    regfile u_rf (
        .clk(clk),
        .raddr1(ds_inst[25:21]), .rdata1(rf_rdata1),   // rs
        .raddr2(ds_inst[20:16]), .rdata2(rf_rdata2),   // rt
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    operand_bypass u_byp (
        .rs(ds_inst[25:21]), .rt(ds_inst[20:16]),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .es_fw_valid(es_fw_valid), .es_fw_we(es_fw_we), .es_is_load(es_is_load),
        .es_fw_addr(es_fw_addr), .es_fw_value(es_fw_value),
        .ms_fw_valid(ms_fw_valid), .ms_fw_we(ms_fw_we),
        .ms_fw_addr(ms_fw_addr), .ms_fw_value(ms_fw_value),
        .ws_fw_valid(ws_fw_valid), .ws_fw_we(ws_fw_we),
        .ws_fw_addr(ws_fw_addr), .ws_fw_value(ws_fw_value),
        .rs_value(es_rs_value), .rt_value(es_rt_value), .ready_go(ready_go)
    );

    branch_resolve u_br (
        .ds_go(ds_to_es_valid), .ds_pc(es_pc), .inst(ds_inst), .br_kind(br_kind),
        .rs_value(es_rs_value), .rt_value(es_rt_value),
        .br_taken(br_taken), .br_target(br_target)
    );

endmodule

`default_nettype wire

// ==== verilog/branch_resolve.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_resolve import id_pkg::*; (
    input  logic        ds_go,
    input  logic [31:0] ds_pc,
    input  logic [31:0] inst,
    input  br_kind_t    br_kind,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    output logic        br_taken,
    output logic [31:0] br_target
);

    logic [31:0] pc_plus4;
    logic [31:0] br_offset;
    logic        rs_eq_rt;
    logic        cond;

    assign pc_plus4  = ds_pc + 32'd4;
    assign br_offset = {{14{inst[15]}}, inst[15:0], 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);

    always_comb begin
        case (br_kind)
            BR_BEQ:              cond = rs_eq_rt;
            BR_BNE:              cond = !rs_eq_rt;
            BR_J, BR_JAL, BR_JR: cond = 1'b1;
            default:             cond = 1'b0;
        endcase
    end

    // only an instruction leaving decode may redirect fetch
    assign br_taken = ds_go && cond;

    always_comb begin
        case (br_kind)
            BR_BEQ, BR_BNE: br_target = pc_plus4 + br_offset;
            BR_JR:          br_target = rs_value;
            default:        br_target = {pc_plus4[31:28], inst[25:0], 2'b00};  // j, jal
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/operand_bypass.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_bypass import id_pkg::*; (
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic [31:0] rf_rdata1,
    input  logic [31:0] rf_rdata2,
    input  logic        es_fw_valid,
    input  logic        es_fw_we,
    input  logic        es_is_load,
    input  logic [4:0]  es_fw_addr,
    input  logic [31:0] es_fw_value,
    input  logic        ms_fw_valid,
    input  logic        ms_fw_we,
    input  logic [4:0]  ms_fw_addr,
    input  logic [31:0] ms_fw_value,
    input  logic        ws_fw_valid,
    input  logic        ws_fw_we,
    input  logic [4:0]  ws_fw_addr,
    input  logic [31:0] ws_fw_value,
    output logic [31:0] rs_value,
    output logic [31:0] rt_value,
    output logic        ready_go
);

    logic es_fwd_ok;
    logic ms_fwd_ok;
    logic ws_fwd_ok;
    logic load_use;

    // load data not yet available in execute
    assign es_fwd_ok = es_fw_valid && es_fw_we && !es_is_load;
    assign ms_fwd_ok = ms_fw_valid && ms_fw_we;
    assign ws_fwd_ok = ws_fw_valid && ws_fw_we;

    // youngest producer wins
    function automatic logic [31:0] fw_pick(input logic [4:0] addr, input logic [31:0] rf_data);
        logic [31:0] value;
        if (addr == REG_ZERO)
            value = 32'd0;
        else if (es_fwd_ok && es_fw_addr == addr)
            value = es_fw_value;
        else if (ms_fwd_ok && ms_fw_addr == addr)
            value = ms_fw_value;
        else if (ws_fwd_ok && ws_fw_addr == addr)
            value = ws_fw_value;   // covers the rf write cycle
        else
            value = rf_data;
        return value;
    endfunction

    always_comb begin
        rs_value = fw_pick(rs, rf_rdata1);
        rt_value = fw_pick(rt, rf_rdata2);
    end

    assign load_use = es_fw_valid && es_is_load && (es_fw_addr != REG_ZERO)
                      && (es_fw_addr == rs || es_fw_addr == rt);
    assign ready_go = !load_use;

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] rf [0:31];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;   // $0 may be written, never read back
        end
    end

    // async reads, r0 hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_decoder import id_pkg::*; (
    input  logic [31:0] inst,
    output alu_op_t     alu_op,
    output logic        src1_is_sa,
    output logic        src1_is_pc,
    output logic        src2_is_imm,
    output logic        src2_is_8,
    output logic        zero_extend_imm,
    output logic        gr_we,
    output logic        mem_we,
    output logic        load_op,
    output logic [4:0]  dest,
    output logic [15:0] imm,
    output br_kind_t    br_kind
);

    opcode_t    op;
    funct_t     fn;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;

    assign op  = opcode_t'(inst[31:26]);
    assign rs  = inst[25:21];
    assign rt  = inst[20:16];
    assign rd  = inst[15:11];
    assign sa  = inst[10:6];
    assign fn  = funct_t'(inst[5:0]);
    assign imm = inst[15:0];

    always_comb begin
        // defaults describe a no-op that writes nothing
        alu_op          = ALU_ADD;
        src1_is_sa      = 1'b0;
        src1_is_pc      = 1'b0;
        src2_is_imm     = 1'b0;
        src2_is_8       = 1'b0;
        zero_extend_imm = 1'b0;
        gr_we           = 1'b0;
        mem_we          = 1'b0;
        load_op         = 1'b0;
        dest            = rd;
        br_kind         = BR_NONE;

        case (op)
            OP_SPECIAL: begin
                if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) begin
                    if (rs == 5'd0) begin       // shifts take sa, rs must be zero
                        src1_is_sa = 1'b1;
                        gr_we      = 1'b1;
                        alu_op     = (fn == FN_SLL) ? ALU_SLL :
                                     (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                end else if (fn == FN_JR) begin
                    if (rt == 5'd0 && rd == 5'd0 && sa == 5'd0) begin
                        br_kind = BR_JR;
                    end
                end else if (sa == 5'd0) begin
                    gr_we = 1'b1;
                    case (fn)
                        FN_ADDU: alu_op = ALU_ADD;
                        FN_SUBU: alu_op = ALU_SUB;
                        FN_SLT:  alu_op = ALU_SLT;
                        FN_SLTU: alu_op = ALU_SLTU;
                        FN_AND:  alu_op = ALU_AND;
                        FN_OR:   alu_op = ALU_OR;
                        FN_XOR:  alu_op = ALU_XOR;
                        FN_NOR:  alu_op = ALU_NOR;
                        default: gr_we  = 1'b0;  // unknown funct
                    endcase
                end
            end
            OP_ADDIU: begin
                src2_is_imm = 1'b1;
                gr_we       = 1'b1;
                dest        = rt;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alu_op          = (op == OP_ANDI) ? ALU_AND :
                                  (op == OP_ORI)  ? ALU_OR  : ALU_XOR;
                src2_is_imm     = 1'b1;
                zero_extend_imm = 1'b1;   // logical ops zero-extend
                gr_we           = 1'b1;
                dest            = rt;
            end
            OP_LUI: begin
                if (rs == 5'd0) begin
                    alu_op      = ALU_LUI;
                    src2_is_imm = 1'b1;
                    gr_we       = 1'b1;
                    dest        = rt;
                end
            end
            OP_LW: begin
                src2_is_imm = 1'b1;   // address = rs + offset
                gr_we       = 1'b1;
                load_op     = 1'b1;
                dest        = rt;
            end
            OP_SW: begin
                src2_is_imm = 1'b1;
                mem_we      = 1'b1;
            end
            OP_BEQ: br_kind = BR_BEQ;
            OP_BNE: br_kind = BR_BNE;
            OP_J:   br_kind = BR_J;
            OP_JAL: begin
                // link value is pc + 8 computed in execute
                src1_is_pc = 1'b1;
                src2_is_8  = 1'b1;
                gr_we      = 1'b1;
                dest       = REG_RA;
                br_kind    = BR_JAL;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/id_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_latch (
    input  logic        clk,
    input  logic        reset,
    input  logic        fs_to_ds_valid,
    input  logic [31:0] fs_pc,
    input  logic [31:0] fs_inst,
    input  logic        es_allowin,
    input  logic        ready_go,
    output logic        ds_allowin,
    output logic        ds_valid,
    output logic [31:0] ds_pc,
    output logic [31:0] ds_inst
);

    // empty, or the held instruction leaves this cycle
    assign ds_allowin = !ds_valid || (ready_go && es_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;   // bubble when fetch has nothing
        end
    end

    // payload only moves on a real transfer
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/id_pkg.sv ====
`default_nettype none

package id_pkg;

    // major opcodes, MIPS encodings
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_J    = 3'd3,
        BR_JAL  = 3'd4,
        BR_JR   = 3'd5
    } br_kind_t;

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd31;   // link register for jal

endpackage

`default_nettype wire
